// ==== include/copper_config.svh ====
/*
 * Build-time constants for the display copper
 * Raster totals must match the video timing that drives h_count and v_count
 * Region bases are full 16-bit XR addresses, low bits are filled by each move
 */
`ifndef COPPER_CONFIG_SVH
`define COPPER_CONFIG_SVH

`default_nettype none

// Copper memory address and PC width, 2K words
`define COPP_PC_W 11
// XR data word width
`define COPP_DATA_W 16
// Beam counter width
`define COPP_POS_W 11

// Raster totals including blanking
`define COPP_H_TOTAL 800
`define COPP_V_TOTAL 525

// Control register number in the XR register space
`define COPP_CTRL_REG 4'h1

// Region base addresses
`define COPP_TILE_BASE 16'h4000
`define COPP_COLOR_BASE 16'h8000
`define COPP_COPPER_BASE 16'hC000

`default_nettype wire

`endif

// ==== logic/copper_isa_pkg.sv ====
/*
 * Copper instruction set
 * Every instruction is two 16-bit words, first word in bits 31:16
 * Opcodes not listed in opcode_t execute as a no-operation
 */
`include "copper_config.svh"
`default_nettype none

package copper_isa_pkg;

    // Top nibble of the first instruction word
    typedef enum logic [3:0] {
        WAIT  = 4'b0000,
        SKIP  = 4'b0010,
        JMP   = 4'b0100,
        MOVER = 4'b1001,
        MOVEF = 4'b1010,
        MOVEP = 4'b1011,
        MOVEC = 4'b1100
    } opcode_t;

    // WAIT, SKIP and JMP view
    // JMP takes its target from the Y field
    typedef struct packed {
        opcode_t                opcode;
        logic                   rsvd_y;
        logic [`COPP_POS_W-1:0] y;
        logic                   rsvd_x;
        logic [`COPP_POS_W-1:0] x;
        logic [1:0]             rsvd_flags;
        logic                   ignore_h;
        logic                   ignore_v;
    } pos_view_t;

    // MOVE view, the writer narrows the address field per region
    typedef struct packed {
        opcode_t                 opcode;
        logic [11:0]             addr;
        logic [`COPP_DATA_W-1:0] data;
    } move_view_t;

    typedef union packed {
        pos_view_t  pos_view;
        move_view_t move_view;
    } copper_insn_u;

endpackage

`default_nettype wire

// ==== logic/copper_bus_pkg.sv ====
/*
 * Copper datapath types
 * Region order follows the MOVE opcodes from MOVER to MOVEC
 */
`default_nettype none

package copper_bus_pkg;

    // Write target of a MOVE
    typedef enum logic [1:0] {
        XR_REG = 2'd0,
        TILE   = 2'd1,
        COLOR  = 2'd2,
        COPPER = 2'd3
    } region_t;

    // Sequencer states
    // INIT only runs after a restart, later fetches start from EXEC
    typedef enum logic [2:0] {
        INIT   = 3'b000,
        WAIT   = 3'b001,
        LATCH1 = 3'b010,
        LATCH2 = 3'b011,
        COMP   = 3'b101,
        EXEC   = 3'b100
    } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/copper_move_if.sv ====
/*
 * Move request from the sequencer to the XR write port
 * A move completes on the edge where move_req and move_done are both high
 * move_done is combinational from move_req and the region busy select
 */
`include "copper_config.svh"
`default_nettype none
`timescale 1ns/100ps

interface copper_move_if;

    logic                    move_req;
    copper_bus_pkg::region_t region;
    logic [11:0]             addr_field;
    logic [`COPP_DATA_W-1:0] data;
    logic                    move_done;

    // Sequencer side
    modport seq (
        output move_req,
        output region,
        output addr_field,
        output data,
        input  move_done
    );

    // Write port side
    modport writer (
        input  move_req,
        input  region,
        input  addr_field,
        input  data,
        output move_done
    );

endinterface

`default_nettype wire

// ==== logic/copper_ctrl_regs.sv ====
/*
 * Copper control register and frame restart detect
 * Register format is bit 15 enable and bits 10:0 initial PC, bits 14:11 ignored
 * frame_restart_o is combinational and high for one beam position per frame
 */
`include "copper_config.svh"
`default_nettype none
`timescale 1ns/100ps

module copper_ctrl_regs (
    input  wire logic                   clk,
    input  wire logic                   copp_reset,
    input  wire logic                   reg_wr_i,
    input  wire logic [3:0]             reg_num_i,
    input  wire logic [15:0]            reg_data_i,
    input  wire logic [`COPP_POS_W-1:0] h_count_i,
    input  wire logic [`COPP_POS_W-1:0] v_count_i,
    output      logic                   copper_en_o,
    output      logic [`COPP_PC_W-1:0]  init_pc_o,
    output      logic                   frame_restart_o
);

    // Restart point, a few clocks before the last line wraps
    localparam logic [`COPP_POS_W-1:0] H_RESTART = `COPP_POS_W'(`COPP_H_TOTAL - 5);
    localparam logic [`COPP_POS_W-1:0] V_RESTART = `COPP_POS_W'(`COPP_V_TOTAL - 1);

    // Control register, new value seen by the sequencer one cycle after the write
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en_o <= 1'b0;
            init_pc_o   <= '0;
        end else if (reg_wr_i && reg_num_i == `COPP_CTRL_REG) begin
            copper_en_o <= reg_data_i[15];
            init_pc_o   <= reg_data_i[`COPP_PC_W-1:0];
        end
    end

    // End of frame, restart the program at the initial PC
    assign frame_restart_o = (h_count_i == H_RESTART) && (v_count_i == V_RESTART);

endmodule

`default_nettype wire

// ==== logic/copper_sequencer.sv ====
/*
 * Copper fetch, compare and execute sequencer
 * Copper memory read data is expected one cycle after the read strobe
 * First instruction after INIT executes 5 cycles later, each following one 5 cycles
 * after the previous EXEC, and a WAIT with both ignore flags stalls until restart
 */
`include "copper_config.svh"
`default_nettype none
`timescale 1ns/100ps

module copper_sequencer (
    input  wire logic                    clk,
    input  wire logic                    copp_reset,
    input  wire logic                    copper_en_i,
    input  wire logic [`COPP_PC_W-1:0]   init_pc_i,
    input  wire logic                    frame_restart_i,
    input  wire logic [`COPP_POS_W-1:0]  h_count_i,
    input  wire logic [`COPP_POS_W-1:0]  v_count_i,
    input  wire logic [`COPP_DATA_W-1:0] cmem_rd_data_i,
    output      logic                    cmem_rd_en_o,
    output      logic [`COPP_PC_W-1:0]   cmem_rd_addr_o,
    copper_move_if.seq                   move
);

    copper_bus_pkg::seq_state_t state;
    copper_isa_pkg::copper_insn_u insn;

    logic [`COPP_PC_W-1:0] pc;
    logic                  rd_strobe;
    logic                  h_reached;
    logic                  v_reached;

    // EXEC decode results
    logic                    cond_met;
    logic                    is_move;
    logic                    exec_advance;
    logic                    exec_recheck;
    logic [`COPP_PC_W-1:0]   exec_pc;
    copper_bus_pkg::region_t move_region;

    // Memory address follows the PC directly
    assign cmem_rd_en_o   = rd_strobe;
    assign cmem_rd_addr_o = pc;

    // Position condition shared by WAIT and SKIP
    // An ignored axis always counts as reached
    assign cond_met = (insn.pos_view.ignore_v || v_reached) &&
                      (insn.pos_view.ignore_h || h_reached);

    always_comb begin
        exec_advance = 1'b0;
        exec_recheck = 1'b0;
        exec_pc      = pc + 1'b1;
        is_move      = 1'b0;
        move_region  = copper_bus_pkg::XR_REG;
        case (insn.pos_view.opcode)
            copper_isa_pkg::WAIT: begin
                // Both flags set means wait for the next frame restart
                if (!(insn.pos_view.ignore_h && insn.pos_view.ignore_v)) begin
                    exec_advance = cond_met;
                    exec_recheck = !cond_met;
                end
            end
            copper_isa_pkg::SKIP: begin
                // PC is on the second word, so +3 steps over one instruction
                exec_advance = 1'b1;
                exec_pc      = cond_met ? pc + 2'd3 : pc + 1'b1;
            end
            copper_isa_pkg::JMP: begin
                exec_advance = 1'b1;
                exec_pc      = insn.pos_view.y;
            end
            copper_isa_pkg::MOVER: begin
                is_move      = 1'b1;
                exec_advance = move.move_done;
            end
            copper_isa_pkg::MOVEF: begin
                is_move      = 1'b1;
                move_region  = copper_bus_pkg::TILE;
                exec_advance = move.move_done;
            end
            copper_isa_pkg::MOVEP: begin
                is_move      = 1'b1;
                move_region  = copper_bus_pkg::COLOR;
                exec_advance = move.move_done;
            end
            copper_isa_pkg::MOVEC: begin
                is_move      = 1'b1;
                move_region  = copper_bus_pkg::COPPER;
                exec_advance = move.move_done;
            end
            // Illegal opcode acts as a no-operation
            default: exec_advance = 1'b1;
        endcase
    end

    // Request only while the sequencer can retire the move in the same cycle
    assign move.move_req   = (state == copper_bus_pkg::EXEC) && is_move &&
                             copper_en_i && !frame_restart_i;
    assign move.region     = move_region;
    assign move.addr_field = insn.move_view.addr;
    assign move.data       = insn.move_view.data;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state     <= copper_bus_pkg::INIT;
            pc        <= '0;
            rd_strobe <= 1'b0;
        end else if (frame_restart_i) begin
            // Restart wins over a disabled copper and any pending move
            state     <= copper_bus_pkg::INIT;
            pc        <= init_pc_i;
            rd_strobe <= 1'b0;
        end else if (copper_en_i) begin
            case (state)
                copper_bus_pkg::INIT: begin
                    state     <= copper_bus_pkg::WAIT;
                    rd_strobe <= 1'b1;
                end
                // First word read in flight, start the second
                copper_bus_pkg::WAIT: begin
                    state     <= copper_bus_pkg::LATCH1;
                    pc        <= pc + 1'b1;
                    rd_strobe <= 1'b1;
                end
                copper_bus_pkg::LATCH1: begin
                    state <= copper_bus_pkg::LATCH2;
                end
                copper_bus_pkg::LATCH2: begin
                    state     <= copper_bus_pkg::COMP;
                    rd_strobe <= 1'b0;
                end
                copper_bus_pkg::COMP: begin
                    state <= copper_bus_pkg::EXEC;
                end
                copper_bus_pkg::EXEC: begin
                    // Next fetch starts straight from EXEC, skipping INIT
                    if (exec_advance) begin
                        state     <= copper_bus_pkg::WAIT;
                        pc        <= exec_pc;
                        rd_strobe <= 1'b1;
                    end else if (exec_recheck) begin
                        state <= copper_bus_pkg::COMP;
                    end
                end
                default: state <= copper_bus_pkg::INIT;
            endcase
        end
    end

    // Instruction words and beam compares
    always_ff @(posedge clk) begin
        if (copper_en_i && state == copper_bus_pkg::LATCH1) begin
            insn[31:16] <= cmem_rd_data_i;
        end
        if (copper_en_i && state == copper_bus_pkg::LATCH2) begin
            insn[15:0] <= cmem_rd_data_i;
        end
        if (copper_en_i && state == copper_bus_pkg::COMP) begin
            v_reached <= v_count_i >= insn.pos_view.y;
            h_reached <= h_count_i >= insn.pos_view.x;
        end
    end

endmodule

`default_nettype wire

// ==== logic/copper_xr_writer.sv ====
/*
 * Shared XR write port for copper moves
 * A busy select high holds the move in the sequencer, nothing is dropped
 * Write strobe, address and data appear one cycle after the move completes
 */
`include "copper_config.svh"
`default_nettype none
`timescale 1ns/100ps

module copper_xr_writer (
    input  wire logic                    clk,
    input  wire logic                    copp_reset,
    input  wire logic                    xr_reg_busy_i,
    input  wire logic                    tile_busy_i,
    input  wire logic                    color_busy_i,
    input  wire logic                    copper_busy_i,
    copper_move_if.writer                move,
    output      logic                    xr_wr_en_o,
    output      logic [15:0]             xr_wr_addr_o,
    output      logic [`COPP_DATA_W-1:0] xr_wr_data_o
);

    localparam logic [15:0] TILE_BASE   = `COPP_TILE_BASE;
    localparam logic [15:0] COLOR_BASE  = `COPP_COLOR_BASE;
    localparam logic [15:0] COPPER_BASE = `COPP_COPPER_BASE;

    logic        busy_sel;
    logic [15:0] addr_next;

    // Busy select and full address of the requested region
    always_comb begin
        case (move.region)
            copper_bus_pkg::TILE: begin
                busy_sel  = tile_busy_i;
                addr_next = {TILE_BASE[15:12], move.addr_field[11:0]};
            end
            copper_bus_pkg::COLOR: begin
                busy_sel  = color_busy_i;
                addr_next = {COLOR_BASE[15:8], move.addr_field[7:0]};
            end
            copper_bus_pkg::COPPER: begin
                busy_sel  = copper_busy_i;
                addr_next = {COPPER_BASE[15:11], move.addr_field[10:0]};
            end
            // XR registers use an 8-bit register number
            default: begin
                busy_sel  = xr_reg_busy_i;
                addr_next = {8'h00, move.addr_field[7:0]};
            end
        endcase
    end

    // Accept in the same cycle whenever the region is free
    assign move.move_done = move.move_req && !busy_sel;

    // One-cycle strobe per completed move
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_en_o <= 1'b0;
        end else begin
            xr_wr_en_o <= move.move_done;
        end
    end

    always_ff @(posedge clk) begin
        if (move.move_done) begin
            xr_wr_addr_o <= addr_next;
            xr_wr_data_o <= move.data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/copper_top.sv ====
/*
 * Display copper top level
 * Copper program memory is external with a one-cycle read
 * Busy inputs are the XR region selects of competing masters
 */
`include "copper_config.svh"
`default_nettype none
`timescale 1ns/100ps

module copper_top (
    input  wire logic                    clk,
    input  wire logic                    copp_reset,
    input  wire logic                    reg_wr_i,
    input  wire logic [3:0]              reg_num_i,
    input  wire logic [15:0]             reg_data_i,
    input  wire logic [`COPP_POS_W-1:0]  h_count_i,
    input  wire logic [`COPP_POS_W-1:0]  v_count_i,
    input  wire logic [`COPP_DATA_W-1:0] cmem_rd_data_i,
    output      logic                    cmem_rd_en_o,
    output      logic [`COPP_PC_W-1:0]   cmem_rd_addr_o,
    input  wire logic                    xr_reg_busy_i,
    input  wire logic                    tile_busy_i,
    input  wire logic                    color_busy_i,
    input  wire logic                    copper_busy_i,
    output      logic                    xr_wr_en_o,
    output      logic [15:0]             xr_wr_addr_o,
    output      logic [`COPP_DATA_W-1:0] xr_wr_data_o
);

    logic                  copper_en;
    logic [`COPP_PC_W-1:0] init_pc;
    logic                  frame_restart;

    copper_move_if move_if_i ();

    // Control register and end of frame detect
    copper_ctrl_regs ctrl_regs_i (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .reg_wr_i        (reg_wr_i),
        .reg_num_i       (reg_num_i),
        .reg_data_i      (reg_data_i),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .copper_en_o     (copper_en),
        .init_pc_o       (init_pc),
        .frame_restart_o (frame_restart)
    );

    copper_sequencer sequencer_i (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .copper_en_i     (copper_en),
        .init_pc_i       (init_pc),
        .frame_restart_i (frame_restart),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .cmem_rd_data_i  (cmem_rd_data_i),
        .cmem_rd_en_o    (cmem_rd_en_o),
        .cmem_rd_addr_o  (cmem_rd_addr_o),
        .move            (move_if_i.seq)
    );

    // Shared write port toward XR registers and memories
    copper_xr_writer xr_writer_i (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .xr_reg_busy_i (xr_reg_busy_i),
        .tile_busy_i   (tile_busy_i),
        .color_busy_i  (color_busy_i),
        .copper_busy_i (copper_busy_i),
        .move          (move_if_i.writer),
        .xr_wr_en_o    (xr_wr_en_o),
        .xr_wr_addr_o  (xr_wr_addr_o),
        .xr_wr_data_o  (xr_wr_data_o)
    );

endmodule

`default_nettype wire

// ==== dv/copper_properties.sv ====
/*
 * Concurrent checks on the copper strobes and sequencer state
 * Bound into copper_top, reaches the sequencer state hierarchically
 * fail_count holds the number of failed assertions
 */
`default_nettype none
`timescale 1ns/100ps

module copper_properties (
    input wire logic                       clk,
    input wire logic                       copp_reset,
    input wire copper_bus_pkg::seq_state_t state_i,
    input wire logic                       move_req_i,
    input wire logic                       move_done_i,
    input wire logic                       frame_restart_i,
    input wire logic                       xr_wr_en_i
);

    int fail_count = 0;

    // Moves are at least one instruction time apart
    strobe_single: assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr_en_i |=> !xr_wr_en_i)
        else begin
            fail_count++;
            $error("xr write strobe high for two cycles");
        end

    reset_state: assert property (@(posedge clk) copp_reset |=> state_i == copper_bus_pkg::INIT)
        else begin
            fail_count++;
            $error("sequencer not in INIT after reset");
        end

    // A stalled move holds the sequencer in EXEC
    req_stall: assert property (@(posedge clk) disable iff (copp_reset)
        move_req_i && !move_done_i && !frame_restart_i |=> state_i == copper_bus_pkg::EXEC)
        else begin
            fail_count++;
            $error("stalled move left EXEC");
        end

    // Restart overrides everything but reset
    restart_init: assert property (@(posedge clk) disable iff (copp_reset)
        frame_restart_i |=> state_i == copper_bus_pkg::INIT)
        else begin
            fail_count++;
            $error("frame restart did not return to INIT");
        end

endmodule

bind copper_top copper_properties props_i (
    .clk             (clk),
    .copp_reset      (copp_reset),
    .state_i         (sequencer_i.state),
    .move_req_i      (move_if_i.move_req),
    .move_done_i     (move_if_i.move_done),
    .frame_restart_i (frame_restart),
    .xr_wr_en_i      (xr_wr_en_o)
);

`default_nettype wire

// ==== dv/copper_tb.sv ====
/*
 * Copper testbench with a 2K word program memory model, one-cycle read
 * Each table entry owns 16 words at entry*16 and ends in a halt WAIT
 * Expected writes come from the region base rules, restarts use the frame end point
 * Beam counts never reach the restart point except when a restart is intended
 */
`include "copper_config.svh"
`default_nettype none
`timescale 1ns/100ps

module copper_tb;

    localparam int NT          = 13;
    localparam int PROG_W      = 10;
    localparam int MAX_EXP     = 4;
    localparam int INSN_CYCLES = 5;
    localparam int MAX_INSN    = PROG_W / 2;
    localparam int WRITE_WAIT  = INSN_CYCLES * MAX_INSN + 10;
    localparam int QUIET       = INSN_CYCLES * MAX_INSN + 10;
    localparam int H_RESTART   = `COPP_H_TOTAL - 5;
    localparam int V_RESTART   = `COPP_V_TOTAL - 1;

    typedef struct {
        string       name;
        logic [15:0] ctrl;
        int          h_pre_max;
        int          h_post;
        int          v_pre;
        int          v_post;
        int          hold;
        logic [3:0]  busy_mask;
        int          busy_cycles;
        int          n_exp;
        int          rerun_after;
    } test_entry_t;

    logic                    clk = 1'b0;
    logic                    copp_reset = 1'b1;
    logic                    reg_wr = 1'b0;
    logic [3:0]              reg_num = '0;
    logic [15:0]             reg_data = '0;
    logic [`COPP_POS_W-1:0]  h_count = '0;
    logic [`COPP_POS_W-1:0]  v_count = '0;
    logic [`COPP_DATA_W-1:0] cmem_rd_data = '0;
    logic [3:0]              busy = '0;
    logic                    cmem_rd_en;
    logic [`COPP_PC_W-1:0]   cmem_rd_addr;
    logic                    xr_wr_en;
    logic [15:0]             xr_wr_addr;
    logic [`COPP_DATA_W-1:0] xr_wr_data;

    logic [15:0] cmem [2**`COPP_PC_W];
    test_entry_t tests [NT];
    logic [15:0] prog [NT][PROG_W];
    logic [15:0] exp_addr [NT][MAX_EXP];
    logic [15:0] exp_data [NT][MAX_EXP];
    logic [15:0] wr_addr_q [$];
    logic [15:0] wr_data_q [$];
    int          rd_count = 0;
    int          errors = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    copper_top copper_top_i (
        .clk            (clk),
        .copp_reset     (copp_reset),
        .reg_wr_i       (reg_wr),
        .reg_num_i      (reg_num),
        .reg_data_i     (reg_data),
        .h_count_i      (h_count),
        .v_count_i      (v_count),
        .cmem_rd_data_i (cmem_rd_data),
        .cmem_rd_en_o   (cmem_rd_en),
        .cmem_rd_addr_o (cmem_rd_addr),
        .xr_reg_busy_i  (busy[0]),
        .tile_busy_i    (busy[1]),
        .color_busy_i   (busy[2]),
        .copper_busy_i  (busy[3]),
        .xr_wr_en_o     (xr_wr_en),
        .xr_wr_addr_o   (xr_wr_addr),
        .xr_wr_data_o   (xr_wr_data)
    );

    always #4 clk = ~clk;

    // Program memory, data one cycle after the read strobe
    always @(posedge clk) begin
        if (cmem_rd_en) begin
            cmem_rd_data <= cmem[cmem_rd_addr];
        end
    end

    // Outputs settle between edges, so collect on the falling edge
    always @(negedge clk) begin
        if (xr_wr_en) begin
            wr_addr_q.push_back(xr_wr_addr);
            wr_data_q.push_back(xr_wr_data);
        end
        if (cmem_rd_en) begin
            rd_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] enc_pos(logic [3:0] op, int y, int x, bit ih, bit iv);
        return {op, 1'b0, y[10:0], 1'b0, x[10:0], 2'b00, ih, iv};
    endfunction

    function automatic logic [31:0] enc_move(logic [3:0] op, logic [11:0] field,
                                             logic [15:0] data);
        return {op, field, data};
    endfunction

    // Region base plus the part of the field that the region uses
    function automatic logic [15:0] region_addr(logic [3:0] op, logic [11:0] field);
        case (op)
            copper_isa_pkg::MOVEF: return 16'h4000 + field[11:0];
            copper_isa_pkg::MOVEP: return 16'h8000 + field[7:0];
            copper_isa_pkg::MOVEC: return 16'hC000 + field[10:0];
            default:               return {8'h00, field[7:0]};
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic set_entry(input int k, input string name, input bit en, input int hpm,
                             input int hpost, input int vpre, input int vpost, input int hold,
                             input logic [3:0] bmask, input int bcyc, input int rerun);
        tests[k] = '{name, {en, 4'b0000, 11'(k * 16)}, hpm, hpost, vpre, vpost, hold,
                     bmask, bcyc, 0, rerun};
        // Halt WAIT in every slot until an instruction is placed
        for (int s = 0; s < MAX_INSN; s++) begin
            prog[k][2*s]   = 16'h0000;
            prog[k][2*s+1] = 16'h0003;
        end
    endtask

    task automatic put_insn(input int k, input int slot, input logic [31:0] word);
        prog[k][2*slot]   = word[31:16];
        prog[k][2*slot+1] = word[15:0];
    endtask

    task automatic expect_move(input int k, input logic [31:0] word);
        exp_addr[k][tests[k].n_exp] = region_addr(word[31:28], word[27:16]);
        exp_data[k][tests[k].n_exp] = word[15:0];
        tests[k].n_exp++;
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        set_entry(0, "disabled", 0, 0, 10, 10, 10, 0, 4'h0, 0, 0);
        put_insn(0, 0, enc_move(copper_isa_pkg::MOVER, 12'h055, 16'h1111));
        set_entry(1, "mover", 1, 0, 10, 10, 10, 0, 4'h0, 0, 0);
        a = enc_move(copper_isa_pkg::MOVER, 12'h312, 16'hA5A5);
        put_insn(1, 0, a);
        expect_move(1, a);
        set_entry(2, "movef", 1, 0, 10, 10, 10, 0, 4'h0, 0, 0);
        a = enc_move(copper_isa_pkg::MOVEF, 12'hABC, 16'h1234);
        put_insn(2, 0, a);
        expect_move(2, a);
        set_entry(3, "movep", 1, 0, 10, 10, 10, 0, 4'h0, 0, 0);
        a = enc_move(copper_isa_pkg::MOVEP, 12'h3C7, 16'hBEEF);
        put_insn(3, 0, a);
        expect_move(3, a);
        set_entry(4, "movec", 1, 0, 10, 10, 10, 0, 4'h0, 0, 0);
        a = enc_move(copper_isa_pkg::MOVEC, 12'hFF5, 16'h0F0F);
        put_insn(4, 0, a);
        expect_move(4, a);
        // WAIT entries, random h below the target until the hold ends
        set_entry(5, "wait xy", 1, 300, 300, 50, 100, 60, 4'h0, 0, 0);
        put_insn(5, 0, enc_pos(copper_isa_pkg::WAIT, 100, 300, 0, 0));
        a = enc_move(copper_isa_pkg::MOVEP, 12'h010, 16'h7777);
        put_insn(5, 1, a);
        expect_move(5, a);
        set_entry(6, "wait ignore v", 1, 200, 250, 10, 10, 60, 4'h0, 0, 0);
        put_insn(6, 0, enc_pos(copper_isa_pkg::WAIT, 400, 200, 0, 1));
        a = enc_move(copper_isa_pkg::MOVEF, 12'h123, 16'h4242);
        put_insn(6, 1, a);
        expect_move(6, a);
        set_entry(7, "wait ignore h", 1, 700, 5, 60, 130, 60, 4'h0, 0, 0);
        put_insn(7, 0, enc_pos(copper_isa_pkg::WAIT, 120, 700, 1, 0));
        a = enc_move(copper_isa_pkg::MOVEC, 12'h456, 16'h9999);
        put_insn(7, 1, a);
        expect_move(7, a);
        // SKIP true omits slot 1, SKIP false runs both moves
        a = enc_move(copper_isa_pkg::MOVER, 12'h021, 16'hAAAA);
        b = enc_move(copper_isa_pkg::MOVER, 12'h022, 16'hBBBB);
        set_entry(8, "skip true", 1, 0, 60, 50, 50, 0, 4'h0, 0, 0);
        put_insn(8, 0, enc_pos(copper_isa_pkg::SKIP, 20, 30, 0, 0));
        put_insn(8, 1, a);
        put_insn(8, 2, b);
        expect_move(8, b);
        set_entry(9, "skip false", 1, 0, 60, 50, 50, 0, 4'h0, 0, 0);
        put_insn(9, 0, enc_pos(copper_isa_pkg::SKIP, 300, 0, 0, 0));
        put_insn(9, 1, a);
        put_insn(9, 2, b);
        expect_move(9, a);
        expect_move(9, b);
        set_entry(10, "jmp", 1, 0, 10, 10, 10, 0, 4'h0, 0, 0);
        put_insn(10, 0, a);
        put_insn(10, 1, enc_pos(copper_isa_pkg::JMP, 10 * 16 + 6, 0, 0, 0));
        put_insn(10, 2, enc_move(copper_isa_pkg::MOVEP, 12'h0EE, 16'hDEAD));
        b = enc_move(copper_isa_pkg::MOVEF, 12'h777, 16'hCAFE);
        put_insn(10, 3, b);
        expect_move(10, a);
        expect_move(10, b);
        // Color region busy for 40 cycles after the restart
        set_entry(11, "busy color", 1, 0, 10, 10, 10, 0, 4'h4, 40, 0);
        a = enc_move(copper_isa_pkg::MOVEP, 12'h0AB, 16'h5A5A);
        put_insn(11, 0, a);
        expect_move(11, a);
        set_entry(12, "illegal restart", 1, 0, 10, 10, 10, 0, 4'h0, 0, 1);
        put_insn(12, 0, 32'hF123_4567);
        a = enc_move(copper_isa_pkg::MOVER, 12'h0C3, 16'h3C3C);
        put_insn(12, 1, a);
        expect_move(12, a);
        expect_move(12, a);
    endtask

    // One restart cycle at the frame end point, then back to the given counts
    task automatic pulse_restart(input int h, input int v);
        h_count <= `COPP_POS_W'(H_RESTART);
        v_count <= `COPP_POS_W'(V_RESTART);
        @(posedge clk);
        h_count <= `COPP_POS_W'(h);
        v_count <= `COPP_POS_W'(v);
    endtask

    task automatic wait_writes(input int n);
        int waited;
        waited = 0;
        while (wr_addr_q.size() < n && waited < WRITE_WAIT) begin
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic run_test(input int k);
        int errs_before;
        int h_pre;
        int first;
        errs_before = errors;
        h_pre = tests[k].h_post;
        if (tests[k].h_pre_max > 0) begin
            h_pre = $urandom % tests[k].h_pre_max;
        end
        @(posedge clk);
        reg_wr   <= 1'b1;
        reg_num  <= `COPP_CTRL_REG;
        reg_data <= tests[k].ctrl;
        @(posedge clk);
        reg_wr <= 1'b0;
        busy   <= tests[k].busy_mask;
        pulse_restart(h_pre, tests[k].v_pre);
        wr_addr_q.delete();
        wr_data_q.delete();
        rd_count = 0;
        if (tests[k].hold > 0) begin
            repeat (tests[k].hold) @(posedge clk);
            compare_value("writes before beam position", wr_addr_q.size(), 0);
            h_count <= `COPP_POS_W'(tests[k].h_post);
            v_count <= `COPP_POS_W'(tests[k].v_post);
        end
        if (tests[k].busy_cycles > 0) begin
            repeat (tests[k].busy_cycles) @(posedge clk);
            compare_value("writes while busy", wr_addr_q.size(), 0);
            busy <= 4'h0;
        end
        first = (tests[k].rerun_after > 0) ? tests[k].rerun_after : tests[k].n_exp;
        wait_writes(first);
        if (tests[k].rerun_after > 0) begin
            @(posedge clk);
            pulse_restart(tests[k].h_post, tests[k].v_post);
            wait_writes(tests[k].n_exp);
        end
        // Quiet window catches extra writes
        repeat (QUIET) @(posedge clk);
        compare_value("write count", wr_addr_q.size(), tests[k].n_exp);
        for (int i = 0; i < tests[k].n_exp && i < wr_addr_q.size(); i++) begin
            compare_value("write address", wr_addr_q[i], exp_addr[k][i]);
            compare_value("write data", wr_data_q[i], exp_data[k][i]);
        end
        if (!tests[k].ctrl[15]) begin
            compare_value("reads while disabled", rd_count, 0);
        end
        if (errors == errs_before) begin
            $display("test %0d %s: ok", k, tests[k].name);
        end else begin
            $display("test %0d %s: %0d errors", k, tests[k].name, errors - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int extra;
        void'($urandom(32'h3f9de102));
        build_table();
        extra = 0;
        for (int k = 0; k < NT; k++) begin
            extra += tests[k].hold + tests[k].busy_cycles + 6;
        end
        cycle_limit = NT * INSN_CYCLES * MAX_INSN * 3 + extra + 40 + 200;
        // Unused words decode as illegal opcodes
        for (int a = 0; a < 2**`COPP_PC_W; a++) begin
            cmem[a] = {5'b11100, a[10:0]};
        end
        for (int k = 0; k < NT; k++) begin
            for (int w = 0; w < PROG_W; w++) begin
                cmem[k*16 + w] = prog[k][w];
            end
        end
        repeat (10) @(posedge clk);
        copp_reset <= 1'b0;
        repeat (20) @(posedge clk);
        compare_value("writes after reset", wr_addr_q.size(), 0);
        compare_value("reads after reset", rd_count, 0);
        for (int k = 0; k < NT; k++) begin
            run_test(k);
        end
        errors += copper_top_i.props_i.fail_count;
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 NT, tests_failed, errors, copper_top_i.props_i.fail_count);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
logic/copper_isa_pkg.sv
logic/copper_bus_pkg.sv
logic/copper_move_if.sv
logic/copper_ctrl_regs.sv
logic/copper_sequencer.sv
logic/copper_xr_writer.sv
logic/copper_top.sv
dv/copper_properties.sv
dv/copper_tb.sv
